/* src/decoder_pkg.sv */
package decoder_pkg;

    // code geometry
    localparam int code_distance_x = 3;
    localparam int code_distance_z = 3;
    localparam int measurement_rounds =
        (code_distance_x > code_distance_z) ? code_distance_x : code_distance_z;
    localparam int address_width = $clog2(measurement_rounds) * 3;
    localparam int pu_count = code_distance_x * code_distance_z * measurement_rounds;

    // split of each row between the two halves
    localparam int left_block = (code_distance_x * code_distance_x - 1) / 2;
    localparam int right_block = ((code_distance_x - 1) * (code_distance_x - 1)) / 2;
    localparam int row_stride = left_block + right_block;
    localparam int frame_count = code_distance_x * right_block;

    localparam int stage_width = 3;
    localparam logic [stage_width-1:0] stage_idle = 3'd0;
    localparam logic [stage_width-1:0] stage_spread_cluster = 3'd1;
    localparam logic [stage_width-1:0] stage_grow_boundary = 3'd2;
    localparam logic [stage_width-1:0] stage_sync_is_odd_cluster = 3'd3;
    localparam logic [stage_width-1:0] stage_measurement_loading = 3'd4;
    localparam logic [stage_width-1:0] stage_result_calculating = 3'd5;

    // minimum cycles spent in each timed stage
    localparam int boundary_grow_delay = 3;
    localparam int spread_cluster_delay = 2;
    localparam int sync_is_odd_cluster_delay = 2;
    localparam int max_delay = 3;
    localparam int delay_width = $clog2(max_delay + 1);

    localparam int iteration_width = 8;
    localparam int cycle_width = 32;
    localparam int deadlock_threshold = 10 * pu_count;

endpackage

/* src/link_pkg.sv */
package link_pkg;

    localparam int link_width = 14;
    localparam int fifo_depth = 16;
    localparam int opcode_width = 3;

    localparam logic [opcode_width-1:0] op_advance = 3'd1;
    localparam logic [opcode_width-1:0] op_finish = 3'd2;
    localparam logic [opcode_width-1:0] op_abort = 3'd3;
    localparam logic [opcode_width-1:0] op_frames_done = 3'd4;

    // stage command, upper bits must stay zero
    typedef struct packed {
        logic [link_width-opcode_width-1:0] zero;
        logic [opcode_width-1:0] opcode;
    } command_view_t;

    // one far-half unit of the result, flag on top marks a frame
    typedef struct packed {
        logic frame_flag;
        logic [link_width-decoder_pkg::address_width-4:0] pad;
        logic touching;
        logic odd;
        logic [decoder_pkg::address_width-1:0] root;
    } frame_view_t;

    typedef union packed {
        command_view_t cmd;
        frame_view_t frame;
    } link_word_t;

endpackage

/* src/link_fifo.sv */
module link_fifo #(
    parameter int width = 14,
    parameter int depth = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic [width-1:0] push_data,
    output logic             full,
    input  logic             pop,
    output logic [width-1:0] head,
    output logic             empty
);

    logic [width-1:0] mem [depth];
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic [$clog2(depth+1)-1:0] count;
    logic do_push;
    logic do_pop;

    assign full = (count == depth);
    assign empty = (count == 0);
    assign do_push = push && !full;
    assign do_pop = pop && !empty;
    // head word shown without a read strobe
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

/* src/stage_controller.sv */
module stage_controller (
    input  logic clk,
    input  logic reset,
    input  logic new_round_start,
    input  logic has_message_flying,
    input  logic has_odd_clusters,
    input  logic has_message_flying_otherside,
    input  logic has_odd_clusters_otherside,
    input  link_pkg::link_word_t in_head,
    input  logic in_empty,
    output logic in_pop,
    output logic frame_accept,
    output logic cmd_valid,
    output link_pkg::link_word_t cmd_word,
    output logic [decoder_pkg::stage_width-1:0] stage,
    output logic result_valid,
    output logic [decoder_pkg::iteration_width-1:0] iteration_counter,
    output logic [decoder_pkg::cycle_width-1:0] cycle_counter,
    output logic deadlock
);

    logic [decoder_pkg::stage_width-1:0] next_stage;
    logic [decoder_pkg::delay_width-1:0] delay_counter;
    logic [decoder_pkg::cycle_width-1:0] stall_counter;
    logic flying_both;
    logic odd_both;
    logic delay_done;
    logic stalled;
    logic is_marker;
    logic sync_decision;
    logic end_accept;

    assign flying_both = has_message_flying || has_message_flying_otherside;
    assign odd_both = has_odd_clusters || has_odd_clusters_otherside;
    assign stalled = stall_counter > decoder_pkg::deadlock_threshold;
    assign is_marker = (in_head.cmd.opcode == link_pkg::op_frames_done) && (in_head.cmd.zero == '0);
    // words outside result collection are dropped
    assign in_pop = !in_empty;

    always_comb begin
        case (stage)
            decoder_pkg::stage_spread_cluster:
                delay_done = delay_counter >= decoder_pkg::spread_cluster_delay;
            decoder_pkg::stage_grow_boundary:
                delay_done = delay_counter >= decoder_pkg::boundary_grow_delay;
            decoder_pkg::stage_sync_is_odd_cluster:
                delay_done = delay_counter >= decoder_pkg::sync_is_odd_cluster_delay;
            default: delay_done = 1'b1;
        endcase
    end

    // one decision per cycle, command goes out with the stage change
    always_comb begin
        next_stage = stage;
        cmd_valid = 1'b0;
        cmd_word = '0;
        cmd_word.cmd.opcode = link_pkg::op_advance;
        sync_decision = 1'b0;
        end_accept = 1'b0;
        frame_accept = 1'b0;
        case (stage)
            decoder_pkg::stage_idle: begin
                if (new_round_start) begin
                    next_stage = decoder_pkg::stage_measurement_loading;
                    cmd_valid = 1'b1;
                end
            end
            decoder_pkg::stage_measurement_loading: begin
                next_stage = decoder_pkg::stage_spread_cluster;
            end
            decoder_pkg::stage_spread_cluster: begin
                if (delay_done && !flying_both) begin
                    next_stage = decoder_pkg::stage_sync_is_odd_cluster;
                    cmd_valid = 1'b1;
                end else if (delay_done && stalled) begin
                    next_stage = decoder_pkg::stage_idle;
                    cmd_valid = 1'b1;
                    cmd_word.cmd.opcode = link_pkg::op_finish;
                end
            end
            decoder_pkg::stage_grow_boundary: begin
                if (delay_done) begin
                    next_stage = decoder_pkg::stage_spread_cluster;
                    cmd_valid = 1'b1;
                end
            end
            decoder_pkg::stage_sync_is_odd_cluster: begin
                if (delay_done && !flying_both) begin
                    sync_decision = 1'b1;
                    cmd_valid = 1'b1;
                    if (odd_both) begin
                        next_stage = decoder_pkg::stage_grow_boundary;
                    end else begin
                        next_stage = decoder_pkg::stage_result_calculating;
                        cmd_word.cmd.opcode = link_pkg::op_finish;
                    end
                end else if (delay_done && stalled) begin
                    next_stage = decoder_pkg::stage_idle;
                    cmd_valid = 1'b1;
                    cmd_word.cmd.opcode = link_pkg::op_abort;
                end
            end
            decoder_pkg::stage_result_calculating: begin
                if (!in_empty && is_marker) begin
                    end_accept = 1'b1;
                    next_stage = decoder_pkg::stage_idle;
                end else if (!in_empty) begin
                    frame_accept = 1'b1;
                end
            end
            default: next_stage = decoder_pkg::stage_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= decoder_pkg::stage_idle;
            delay_counter <= '0;
        end else begin
            stage <= next_stage;
            if (next_stage != stage) begin
                delay_counter <= '0;
            end else if (!delay_done) begin
                delay_counter <= delay_counter + 1'b1;
            end
        end
    end

    // stall only accumulates while waiting on the flags
    always_ff @(posedge clk) begin
        if (reset) begin
            stall_counter <= '0;
            deadlock <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            if (stage == decoder_pkg::stage_spread_cluster
                    || stage == decoder_pkg::stage_sync_is_odd_cluster) begin
                stall_counter <= stall_counter + 1'b1;
            end else if (stage != decoder_pkg::stage_result_calculating) begin
                stall_counter <= '0;
            end
            if (new_round_start) begin
                deadlock <= 1'b0;
                result_valid <= 1'b0;
            end else begin
                deadlock <= deadlock || stalled;
                result_valid <= result_valid || end_accept;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_counter <= '0;
            cycle_counter <= '0;
        end else begin
            if (stage == decoder_pkg::stage_measurement_loading) begin
                iteration_counter <= '0;
                cycle_counter <= 1;
            end else begin
                if (sync_decision) begin
                    iteration_counter <= iteration_counter + 1'b1;
                end
                if (!result_valid && stage != decoder_pkg::stage_idle) begin
                    cycle_counter <= cycle_counter + 1'b1;
                end
            end
        end
    end

    a_cmd_on_change: assert property (@(posedge clk) disable iff (reset)
        cmd_valid |=> stage != $past(stage));
    // marker can only follow a frame, so collection is still running
    a_frame_in_result: assert property (@(posedge clk) disable iff (reset)
        frame_accept |=> stage == decoder_pkg::stage_result_calculating);

endmodule

/* src/boundary_merge.sv */
module boundary_merge (
    input  logic clk,
    input  logic reset,
    input  logic new_round_start,
    input  logic frame_accept,
    input  link_pkg::link_word_t frame_word,
    input  logic [decoder_pkg::pu_count-1:0] is_touching_boundaries,
    input  logic [decoder_pkg::pu_count-1:0] is_odd_cardinalities,
    input  logic [decoder_pkg::pu_count*decoder_pkg::address_width-1:0] roots,
    output logic [decoder_pkg::pu_count-1:0] net_is_touching_boundaries,
    output logic [decoder_pkg::pu_count-1:0] net_is_odd_cardinalities,
    output logic [decoder_pkg::pu_count*decoder_pkg::address_width-1:0] net_roots
);

    logic [$clog2(decoder_pkg::frame_count)-1:0] frame_index;

    always_ff @(posedge clk) begin
        if (reset || new_round_start) begin
            frame_index <= '0;
        end else if (frame_accept) begin
            frame_index <= (frame_index == decoder_pkg::frame_count - 1) ? '0 : frame_index + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        int unit;
        unit = (frame_index / decoder_pkg::right_block) * decoder_pkg::row_stride
            + decoder_pkg::left_block + (frame_index % decoder_pkg::right_block);
        if (reset) begin
            net_is_touching_boundaries <= '0;
            net_is_odd_cardinalities <= '0;
            net_roots <= '0;
        end else if (frame_accept) begin
            // local half of every row is taken once per result
            if (frame_index == 0) begin
                for (int row = 0; row < decoder_pkg::code_distance_x; row++) begin
                    net_is_touching_boundaries[row*decoder_pkg::row_stride +: decoder_pkg::left_block]
                        <= is_touching_boundaries[row*decoder_pkg::row_stride +:
                                                  decoder_pkg::left_block];
                    net_is_odd_cardinalities[row*decoder_pkg::row_stride +: decoder_pkg::left_block]
                        <= is_odd_cardinalities[row*decoder_pkg::row_stride +:
                                                decoder_pkg::left_block];
                    net_roots[row*decoder_pkg::row_stride*decoder_pkg::address_width +:
                              decoder_pkg::left_block*decoder_pkg::address_width]
                        <= roots[row*decoder_pkg::row_stride*decoder_pkg::address_width +:
                                 decoder_pkg::left_block*decoder_pkg::address_width];
                end
            end
            // far-half unit lands right of the local block
            net_is_touching_boundaries[unit] <= frame_word.frame.touching;
            net_is_odd_cardinalities[unit] <= frame_word.frame.odd;
            net_roots[unit*decoder_pkg::address_width +: decoder_pkg::address_width]
                <= frame_word.frame.root;
        end
    end

endmodule

/* src/decoder_link_top.sv */
module decoder_link_top (
    input  logic clk,
    input  logic reset,
    input  logic new_round_start,
    input  logic has_message_flying,
    input  logic has_odd_clusters,
    input  logic has_message_flying_otherside,
    input  logic has_odd_clusters_otherside,
    input  logic [decoder_pkg::pu_count-1:0] is_touching_boundaries,
    input  logic [decoder_pkg::pu_count-1:0] is_odd_cardinalities,
    input  logic [decoder_pkg::pu_count*decoder_pkg::address_width-1:0] roots,
    input  logic [link_pkg::link_width-1:0] link_in_data,
    input  logic link_in_valid,
    output logic link_in_ready,
    output logic [link_pkg::link_width-1:0] link_out_data,
    output logic link_out_valid,
    input  logic link_out_ready,
    output logic [decoder_pkg::stage_width-1:0] stage,
    output logic result_valid,
    output logic [decoder_pkg::iteration_width-1:0] iteration_counter,
    output logic [decoder_pkg::cycle_width-1:0] cycle_counter,
    output logic deadlock,
    output logic [decoder_pkg::pu_count-1:0] net_is_touching_boundaries,
    output logic [decoder_pkg::pu_count-1:0] net_is_odd_cardinalities,
    output logic [decoder_pkg::pu_count*decoder_pkg::address_width-1:0] net_roots
);

    link_pkg::link_word_t in_head;
    link_pkg::link_word_t cmd_word;
    logic in_full;
    logic in_empty;
    logic in_pop;
    logic out_empty;
    logic frame_accept;
    logic cmd_valid;

    assign link_in_ready = !in_full;
    assign link_out_valid = !out_empty;

    link_fifo #(.width(link_pkg::link_width), .depth(link_pkg::fifo_depth)) in_queue (
        .clk(clk), .reset(reset),
        .push(link_in_valid), .push_data(link_in_data), .full(in_full),
        .pop(in_pop), .head(in_head), .empty(in_empty)
    );

    stage_controller controller (
        .clk(clk), .reset(reset), .new_round_start(new_round_start),
        .has_message_flying(has_message_flying), .has_odd_clusters(has_odd_clusters),
        .has_message_flying_otherside(has_message_flying_otherside),
        .has_odd_clusters_otherside(has_odd_clusters_otherside),
        .in_head(in_head), .in_empty(in_empty), .in_pop(in_pop), .frame_accept(frame_accept),
        .cmd_valid(cmd_valid), .cmd_word(cmd_word), .stage(stage), .result_valid(result_valid),
        .iteration_counter(iteration_counter), .cycle_counter(cycle_counter),
        .deadlock(deadlock)
    );

    boundary_merge merge (
        .clk(clk), .reset(reset), .new_round_start(new_round_start),
        .frame_accept(frame_accept), .frame_word(in_head),
        .is_touching_boundaries(is_touching_boundaries),
        .is_odd_cardinalities(is_odd_cardinalities), .roots(roots),
        .net_is_touching_boundaries(net_is_touching_boundaries),
        .net_is_odd_cardinalities(net_is_odd_cardinalities), .net_roots(net_roots)
    );

    // ready from the far half only counts while a word is waiting
    link_fifo #(.width(link_pkg::link_width), .depth(link_pkg::fifo_depth)) out_queue (
        .clk(clk), .reset(reset),
        .push(cmd_valid), .push_data(cmd_word), .full(),
        .pop(link_out_ready && !out_empty), .head(link_out_data), .empty(out_empty)
    );

endmodule

/* sim/tb_reference.svh */
// lcg state, fixed seed so every run draws the same stimulus
logic [31:0] rng_state = 32'h98aa590c;

// {touching, odd, roots} packed the same way as the DUT outputs
localparam int net_width = 2 * decoder_pkg::pu_count
    + decoder_pkg::pu_count * decoder_pkg::address_width;

function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
endfunction

function automatic int random_below(input int n);
    logic [31:0] r;
    r = next_random();
    return int'(r[30:8] % n);
endfunction

// upper half of each state only, the low bits repeat too soon
function automatic logic [255:0] random_vector();
    logic [255:0] v;
    logic [31:0] r;
    for (int i = 0; i < 16; i++) begin
        r = next_random();
        v[i*16 +: 16] = r[31:16];
    end
    return v;
endfunction

function automatic logic [link_pkg::link_width-1:0] command_word(input logic [2:0] opcode);
    return {11'b0, opcode};
endfunction

// frame layout: root low, then odd, touching, pad and the frame flag on top
function automatic logic [link_pkg::link_width-1:0] make_frame(
    input logic [5:0] root,
    input logic odd,
    input logic touching
);
    return {1'b1, 5'b0, touching, odd, root};
endfunction

// start, three per odd iteration, then the last spread and the finish
function automatic logic [link_pkg::link_width-1:0] expected_command(input int k, input int index);
    if (index == 3 * k + 2) begin
        return command_word(link_pkg::op_finish);
    end
    return command_word(link_pkg::op_advance);
endfunction

function automatic logic [net_width-1:0] merge_reference(
    input logic [net_width-1:0] prior,
    input logic [decoder_pkg::pu_count-1:0] touch_in,
    input logic [decoder_pkg::pu_count-1:0] odd_in,
    input logic [decoder_pkg::pu_count*decoder_pkg::address_width-1:0] root_in,
    input logic [decoder_pkg::frame_count*link_pkg::link_width-1:0] frames
);
    logic [decoder_pkg::pu_count-1:0] t;
    logic [decoder_pkg::pu_count-1:0] o;
    logic [decoder_pkg::pu_count*decoder_pkg::address_width-1:0] r;
    logic [link_pkg::link_width-1:0] word;
    int unit;
    {t, o, r} = prior;
    // four local units open each row of six
    for (int row = 0; row < 3; row++) begin
        for (int col = 0; col < 4; col++) begin
            unit = row * 6 + col;
            t[unit] = touch_in[unit];
            o[unit] = odd_in[unit];
            r[unit*6 +: 6] = root_in[unit*6 +: 6];
        end
    end
    // two far units close each row
    for (int f = 0; f < 6; f++) begin
        unit = (f / 2) * 6 + 4 + (f % 2);
        word = frames[f*link_pkg::link_width +: link_pkg::link_width];
        t[unit] = word[7];
        o[unit] = word[6];
        r[unit*6 +: 6] = word[5:0];
    end
    return {t, o, r};
endfunction

task automatic check_value(
    input logic [net_width-1:0] actual,
    input logic [net_width-1:0] expected,
    input string what
);
    if (actual !== expected) begin
        $display("Error at time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        $display("Something failed");
        $fatal(1);
    end
endtask

/* sim/tb_decoder_link.sv */
module tb_decoder_link;

    localparam int lw = link_pkg::link_width;
    localparam int pu = decoder_pkg::pu_count;
    localparam int aw = decoder_pkg::address_width;
    // five normal rounds at up to six iterations each, plus the deadlock round
    localparam int round_limit = 6 * 100 + 60;
    localparam int watchdog_cycles = 16 + 5 * round_limit + decoder_pkg::deadlock_threshold + 200;

    logic clk;
    logic reset;
    logic new_round_start;
    logic has_message_flying;
    logic has_odd_clusters;
    logic has_message_flying_otherside;
    logic has_odd_clusters_otherside;
    logic [pu-1:0] is_touching_boundaries;
    logic [pu-1:0] is_odd_cardinalities;
    logic [pu*aw-1:0] roots;
    logic [lw-1:0] link_in_data;
    logic link_in_valid;
    logic link_in_ready;
    logic [lw-1:0] link_out_data;
    logic link_out_valid;
    logic link_out_ready;
    logic [decoder_pkg::stage_width-1:0] stage;
    logic result_valid;
    logic [decoder_pkg::iteration_width-1:0] iteration_counter;
    logic [decoder_pkg::cycle_width-1:0] cycle_counter;
    logic deadlock;
    logic [pu-1:0] net_is_touching_boundaries;
    logic [pu-1:0] net_is_odd_cardinalities;
    logic [pu*aw-1:0] net_roots;

    `include "tb_reference.svh"

    int odd_target = 0;
    bit hold_flying = 0;
    bit throttle = 0;
    bit finish_seen = 0;
    logic [lw-1:0] expected_q[$];
    logic [net_width-1:0] net_expected = '0;

    decoder_link_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Something failed");
        $fatal(1);
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // far-half flags, short message bursts and odd clusters until K decisions
    initial begin
        int burst;
        burst = 0;
        forever begin
            next_cycle();
            if (hold_flying) begin
                has_message_flying = 1'b1;
                has_message_flying_otherside = 1'b0;
            end else if (burst > 0) begin
                burst--;
            end else if (random_below(6) == 0) begin
                burst = 1 + random_below(4);
                has_message_flying = random_below(2) == 1;
                has_message_flying_otherside = !has_message_flying;
            end else begin
                has_message_flying = 1'b0;
                has_message_flying_otherside = 1'b0;
            end
            has_odd_clusters = (iteration_counter < odd_target) && random_below(2) == 1;
            has_odd_clusters_otherside = (iteration_counter < odd_target) && !has_odd_clusters;
        end
    end

    // back-pressure stretches stay short, so out_queue never nears 16 words
    initial begin
        int hold;
        hold = 0;
        forever begin
            next_cycle();
            if (!throttle) begin
                link_out_ready = 1'b1;
            end else if (hold > 0) begin
                hold--;
            end else begin
                link_out_ready = random_below(3) != 0;
                hold = random_below(5);
            end
        end
    end

    // a word leaves out_queue on the next rising edge
    always @(negedge clk) begin
        logic [lw-1:0] want;
        if (!reset) begin
            check_value(link_in_ready, 1'b1, "link_in_ready");
            if (link_out_valid && link_out_ready) begin
                if (expected_q.size() == 0) begin
                    $display("command %0h left the DUT when none was expected", link_out_data);
                    $display("Something failed");
                    $fatal(1);
                end
                want = expected_q.pop_front();
                check_value(link_out_data, want, "outgoing command");
                finish_seen = finish_seen || (want == command_word(link_pkg::op_finish));
            end
        end
    end

    task automatic start_round();
        new_round_start = 1'b1;
        next_cycle();
        new_round_start = 1'b0;
        check_value(deadlock, 1'b0, "deadlock after new_round_start");
        check_value(result_valid, 1'b0, "result_valid after new_round_start");
    endtask

    task automatic run_round(input int k);
        logic [255:0] bits;
        logic [decoder_pkg::frame_count*lw-1:0] frames;
        logic [decoder_pkg::cycle_width-1:0] held;
        bits = random_vector();
        is_touching_boundaries = bits[pu-1:0];
        bits = random_vector();
        is_odd_cardinalities = bits[pu-1:0];
        bits = random_vector();
        roots = bits[pu*aw-1:0];
        for (int f = 0; f < decoder_pkg::frame_count; f++) begin
            bits = random_vector();
            frames[f*lw +: lw] = make_frame(bits[5:0], bits[6], bits[7]);
        end
        for (int i = 0; i < 3 * k + 3; i++) begin
            expected_q.push_back(expected_command(k, i));
        end
        odd_target = k;
        finish_seen = 0;
        start_round();
        while (!finish_seen) next_cycle();
        // far half answers with its frames and the end marker
        link_in_valid = 1'b1;
        for (int f = 0; f < decoder_pkg::frame_count; f++) begin
            link_in_data = frames[f*lw +: lw];
            next_cycle();
        end
        link_in_data = command_word(link_pkg::op_frames_done);
        next_cycle();
        link_in_valid = 1'b0;
        while (!result_valid) next_cycle();
        net_expected = merge_reference(net_expected, is_touching_boundaries,
                                       is_odd_cardinalities, roots, frames);
        check_value({net_is_touching_boundaries, net_is_odd_cardinalities, net_roots},
                    net_expected, "merged result arrays");
        check_value(iteration_counter, k + 1, "iteration_counter");
        check_value(stage, decoder_pkg::stage_idle, "stage after result");
        held = cycle_counter;
        repeat (5) next_cycle();
        check_value(cycle_counter, held, "cycle_counter after result");
        while (expected_q.size() != 0) next_cycle();
    endtask

    task automatic run_deadlock();
        expected_q.push_back(command_word(link_pkg::op_advance));
        expected_q.push_back(command_word(link_pkg::op_finish));
        hold_flying = 1;
        odd_target = 0;
        start_round();
        while (!deadlock) next_cycle();
        check_value(stage, decoder_pkg::stage_idle, "stage after deadlock");
        while (expected_q.size() != 0) next_cycle();
        hold_flying = 0;
    endtask

    initial begin
        reset = 1'b1;
        new_round_start = 1'b0;
        has_message_flying = 1'b0;
        has_odd_clusters = 1'b0;
        has_message_flying_otherside = 1'b0;
        has_odd_clusters_otherside = 1'b0;
        is_touching_boundaries = '0;
        is_odd_cardinalities = '0;
        roots = '0;
        link_in_data = '0;
        link_in_valid = 1'b0;
        link_out_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value(stage, decoder_pkg::stage_idle, "stage after reset");
        check_value({result_valid, deadlock, link_out_valid}, 3'b000, "status bits after reset");
        check_value({iteration_counter, cycle_counter}, '0, "counters after reset");
        check_value({net_is_touching_boundaries, net_is_odd_cardinalities, net_roots}, '0,
                    "result arrays after reset");
        for (int r = 0; r < 4; r++) begin
            throttle = r >= 2;
            run_round(random_below(6));
        end
        throttle = 0;
        run_deadlock();
        run_round(random_below(6));
        repeat (4) next_cycle();
        $display("Everything OK");
        $finish;
    end

endmodule

/* decoder_link.f */
src/decoder_pkg.sv
src/link_pkg.sv
src/link_fifo.sv
src/stage_controller.sv
src/boundary_merge.sv
src/decoder_link_top.sv
+incdir+sim
sim/tb_decoder_link.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_decoder_link
FILELIST ?= decoder_link.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
